/* verilog/rs5_pkg.sv */
/*
 * Shared types and encodings for the four-stage RS5 integer core.
 * Only the kept RV32I subset has an operation code; anything else
 * decodes to OP_NOP and retires without effect.
 */
package rs5_pkg;

    // Data and address word
    typedef logic [31:0] word_t;
    // Register index, x0 to x31
    typedef logic [4:0]  reg_addr_t;
    // Wrong-path tag, bumped on every taken jump
    typedef logic [2:0]  tag_t;
    // One bit per byte lane
    typedef logic [3:0]  strb_t;

    ////////////////////
    // Operations
    ////////////////////

    // Immediate forms share the register-register codes
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_XOR = 4'd5,
        OP_SLT = 4'd6,
        OP_LW  = 4'd7,
        OP_SW  = 4'd8,
        OP_SB  = 4'd9,
        OP_BEQ = 4'd10,
        OP_BNE = 4'd11,
        OP_JAL = 4'd12
    } op_e;

    ////////////////////
    // Major opcodes
    ////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // ADDI x0,x0,0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

/* verilog/rs5_fetch.sv */
/*
 * Program counter for a synchronous instruction memory: the word at
 * instruction_address_o arrives one cycle later, together with pc_o and tag_o.
 * Jump targets are assumed word aligned.
 */
`timescale 1ns/100ps

module rs5_fetch
    import rs5_pkg::*;
#(
    parameter word_t RESET_PC = '0
)(
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  stall_i,
    input  logic  hazard_i,
    input  logic  jump_i,
    input  word_t jump_target_i,
    output word_t instruction_address_o,
    output word_t pc_o,
    output tag_t  tag_o
);

    word_t pc;
    tag_t  tag;

    // Address goes straight to the memory
    assign instruction_address_o = pc;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc    <= RESET_PC;
            tag   <= '0;
            pc_o  <= RESET_PC;
            tag_o <= '0;
        end
        else if (!stall_i) begin
            // Redirect, new tag marks everything fetched from here on
            if (jump_i) begin
                pc  <= jump_target_i;
                tag <= tag + 3'd1;
            end
            else if (!hazard_i) begin
                pc <= pc + 32'd4;
            end
            // Copies follow the word now being read, old tag on a jump
            if (!hazard_i) begin
                pc_o  <= pc;
                tag_o <= tag;
            end
        end
    end

    // Misaligned PC means a bad target reached fetch
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        pc[1:0] == 2'b00)
        else $error("fetch PC not word aligned: %h", pc);

endmodule

/* verilog/rs5_regbank.sv */
/*
 * x1..x31 with two read ports and one write port. A read of the register
 * written in the same cycle returns the new value. Writes to x0 must not occur.
 */
`timescale 1ns/100ps

module rs5_regbank
    import rs5_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  logic      we_i,
    input  word_t     wdata_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end
        else if (we_i) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // x0 reads zero, then write bypass, then stored value
    assign rdata1_o = (rs1_i == '0)               ? '0      :
                      (we_i && rd_i == rs1_i)     ? wdata_i : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0)               ? '0      :
                      (we_i && rd_i == rs2_i)     ? wdata_i : regs[rs2_i];

    // Retire must filter x0 destinations
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(we_i && rd_i == '0))
        else $error("register bank write to x0");

endmodule

/* verilog/rs5_decode.sv */
/*
 * Decodes the kept RV32I subset and forwards from execute. A load-use match
 * inserts one bubble. The word under decode is replayed from a local copy
 * after a stall or hazard, since the memory has moved on by then.
 */
`timescale 1ns/100ps

module rs5_decode
    import rs5_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      stall_i,
    input  word_t     instruction_i,
    input  word_t     pc_i,
    input  tag_t      tag_i,
    input  word_t     rdata1_i,
    input  word_t     rdata2_i,
    input  reg_addr_t fwd_rd_i,
    input  word_t     fwd_data_i,
    input  logic      fwd_is_load_i,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output logic      hazard_o,
    output op_e       op_o,
    output reg_addr_t rd_o,
    output word_t     operand1_o,
    output word_t     operand2_o,
    output word_t     store_data_o,
    output word_t     pc_o,
    output tag_t      tag_o
);

    logic       held;
    word_t      saved_instr;
    word_t      instr;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i, imm_s, imm_b, imm_j;
    logic       fwd1, fwd2;
    word_t      src1, src2;
    op_e        op;
    reg_addr_t  rd;
    word_t      opa, opb, third;

    ////////////////////
    // Fields
    ////////////////////

    // Replay copy while held
    assign instr = held ? saved_instr : instruction_i;
    assign rs1_o = instr[19:15];
    assign rs2_o = instr[24:20];
    assign f3    = instr[14:12];
    assign f7    = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Execute result wins over the bank, x0 never forwarded
    assign fwd1     = (fwd_rd_i != '0) && (rs1_o == fwd_rd_i);
    assign fwd2     = (fwd_rd_i != '0) && (rs2_o == fwd_rd_i);
    assign src1     = fwd1 ? fwd_data_i : rdata1_i;
    assign src2     = fwd2 ? fwd_data_i : rdata2_i;
    // Load data not there yet
    assign hazard_o = fwd_is_load_i && (fwd1 || fwd2);

    ////////////////////
    // Decoder
    ////////////////////

    always_comb begin
        op    = OP_NOP;
        opa   = src1;
        opb   = src2;
        third = src2;
        case (instr[6:0])
            OPC_OP: begin
                if (f7 == 7'b0100000 && f3 == 3'b000) begin
                    op = OP_SUB;
                end
                else if (f7 == 7'b0000000) begin
                    case (f3)
                        3'b000:  op = OP_ADD;
                        3'b010:  op = OP_SLT;
                        3'b100:  op = OP_XOR;
                        3'b110:  op = OP_OR;
                        3'b111:  op = OP_AND;
                        default: op = OP_NOP;
                    endcase
                end
            end
            OPC_OPIMM: begin
                // Only ADDI kept
                opb = imm_i;
                if (f3 == 3'b000) op = OP_ADD;
            end
            OPC_LOAD: begin
                opb = imm_i;
                if (f3 == 3'b010) op = OP_LW;
            end
            OPC_STORE: begin
                opb = imm_s;
                if (f3 == 3'b010)      op = OP_SW;
                else if (f3 == 3'b000) op = OP_SB;
            end
            OPC_BRANCH: begin
                // Offset rides in the store data slot
                third = imm_b;
                if (f3 == 3'b000)      op = OP_BEQ;
                else if (f3 == 3'b001) op = OP_BNE;
            end
            OPC_JAL: begin
                op  = OP_JAL;
                opa = pc_i;
                opb = imm_j;
            end
            default: op = OP_NOP;
        endcase
        // Destination only for ops that write back
        rd = (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_LW, OP_JAL})
             ? instr[11:7] : '0;
    end

    ////////////////////
    // Decode to execute
    ////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // First cycle out of reset decodes a NOP
            held        <= 1'b1;
            saved_instr <= NOP_INSTR;
            op_o        <= OP_NOP;
            rd_o        <= '0;
            tag_o       <= '0;
        end
        else begin
            held        <= stall_i || hazard_o;
            saved_instr <= instr;
            if (!stall_i) begin
                op_o  <= hazard_o ? OP_NOP : op;
                rd_o  <= hazard_o ? '0 : rd;
                tag_o <= tag_i;
            end
        end
    end

    // Operand payload
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            operand1_o   <= opa;
            operand2_o   <= opb;
            store_data_o <= third;
            pc_o         <= pc_i;
        end
    end

endmodule

/* verilog/rs5_execute.sv */
/*
 * ALU, branch resolution, memory request and the retire register.
 * Tags that differ from the current one are killed: no jump, no write back.
 * Load data is expected on mem_data_i in the cycle after the request.
 */
`timescale 1ns/100ps

module rs5_execute
    import rs5_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      stall_i,
    input  op_e       op_i,
    input  reg_addr_t rd_i,
    input  word_t     operand1_i,
    input  word_t     operand2_i,
    input  word_t     store_data_i,
    input  word_t     pc_i,
    input  tag_t      tag_i,
    input  word_t     mem_data_i,
    output logic      jump_o,
    output word_t     jump_target_o,
    output reg_addr_t fwd_rd_o,
    output word_t     fwd_data_o,
    output logic      fwd_is_load_o,
    output logic      killed_o,
    output word_t     mem_address_o,
    output logic      mem_read_o,
    output strb_t     mem_write_enable_o,
    output word_t     mem_write_data_o,
    output logic      we_o,
    output reg_addr_t rd_o,
    output word_t     wdata_o
);

    tag_t      curr_tag;
    logic      killed;
    logic      equal;
    logic      taken;
    word_t     sum;
    word_t     result;
    logic      ret_we;
    logic      ret_is_load;
    reg_addr_t ret_rd;
    word_t     ret_result;

    ////////////////////
    // Tag and branch
    ////////////////////

    assign killed   = (tag_i != curr_tag);
    assign killed_o = killed;

    // Follows the fetch tag, one step per taken jump
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            curr_tag <= '0;
        end
        else if (!stall_i && jump_o) begin
            curr_tag <= curr_tag + 3'd1;
        end
    end

    assign sum   = operand1_i + operand2_i;
    assign equal = (operand1_i == operand2_i);
    assign taken = (op_i == OP_JAL) ||
                   (op_i == OP_BEQ && equal) ||
                   (op_i == OP_BNE && !equal);

    assign jump_o        = taken && !killed;
    // JAL adds pc+imm in the ALU, branches carry the offset separately
    assign jump_target_o = (op_i == OP_JAL) ? sum : pc_i + store_data_i;

    ////////////////////
    // ALU
    ////////////////////

    always_comb begin
        case (op_i)
            OP_SUB:  result = operand1_i - operand2_i;
            OP_AND:  result = operand1_i & operand2_i;
            OP_OR:   result = operand1_i | operand2_i;
            OP_XOR:  result = operand1_i ^ operand2_i;
            OP_SLT:  result = {31'b0, $signed(operand1_i) < $signed(operand2_i)};
            // Link value
            OP_JAL:  result = pc_i + 32'd4;
            default: result = sum;
        endcase
    end

    // Killed ops never forward
    assign fwd_rd_o      = killed ? '0 : rd_i;
    assign fwd_data_o    = result;
    assign fwd_is_load_o = (op_i == OP_LW) && !killed;

    ////////////////////
    // Memory request
    ////////////////////

    assign mem_address_o = sum;
    assign mem_read_o    = (op_i == OP_LW);

    always_comb begin
        case (op_i)
            OP_SW:   mem_write_enable_o = 4'b1111;
            OP_SB:   mem_write_enable_o = 4'b0001 << sum[1:0];
            default: mem_write_enable_o = 4'b0000;
        endcase
    end

    // Byte copied to all lanes, the strobe picks one
    assign mem_write_data_o = (op_i == OP_SB) ? {4{store_data_i[7:0]}} : store_data_i;

    ////////////////////
    // Retire
    ////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ret_we      <= 1'b0;
            ret_is_load <= 1'b0;
            ret_rd      <= '0;
        end
        else if (!stall_i) begin
            ret_we      <= !killed && (rd_i != '0);
            ret_is_load <= (op_i == OP_LW);
            ret_rd      <= rd_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ret_result <= result;
        end
    end

    assign we_o    = ret_we;
    assign rd_o    = ret_rd;
    // Load data arrives while the load sits here
    assign wdata_o = ret_is_load ? mem_data_i : ret_result;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mem_read_o && mem_write_enable_o != '0))
        else $error("read and write requested together");

endmodule

/* verilog/rs5.sv */
/*
 * RS5 top level: fetch, decode, register bank, execute and retire.
 * Instruction and data memories are synchronous with one cycle of latency.
 * stall_i freezes every stage and masks the memory enable.
 */
`timescale 1ns/100ps

module rs5
    import rs5_pkg::*;
#(
    parameter word_t RESET_PC = '0
)(
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  stall_i,
    input  word_t instruction_i,
    input  word_t mem_data_i,
    output word_t instruction_address_o,
    output word_t mem_address_o,
    output word_t mem_data_o,
    output logic  mem_operation_enable_o,
    output strb_t mem_write_enable_o
);

    ////////////////////
    // Stage links
    ////////////////////

    logic      jump, hazard, killed, mem_read;
    word_t     jump_target;
    word_t     pc_decode, pc_execute;
    tag_t      tag_decode, tag_execute;
    reg_addr_t rs1, rs2, rd_execute;
    word_t     rdata1, rdata2;
    op_e       op_execute;
    word_t     operand1, operand2, store_data;
    reg_addr_t fwd_rd;
    word_t     fwd_data;
    logic      fwd_is_load;
    logic      we;
    reg_addr_t rd_retire;
    word_t     wdata;

    rs5_fetch #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .stall_i               (stall_i),
        .hazard_i              (hazard),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_decode),
        .tag_o                 (tag_decode)
    );

    rs5_decode i_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .pc_i          (pc_decode),
        .tag_i         (tag_decode),
        .rdata1_i      (rdata1),
        .rdata2_i      (rdata2),
        .fwd_rd_i      (fwd_rd),
        .fwd_data_i    (fwd_data),
        .fwd_is_load_i (fwd_is_load),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .hazard_o      (hazard),
        .op_o          (op_execute),
        .rd_o          (rd_execute),
        .operand1_o    (operand1),
        .operand2_o    (operand2),
        .store_data_o  (store_data),
        .pc_o          (pc_execute),
        .tag_o         (tag_execute)
    );

    rs5_regbank i_regbank (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .rd_i     (rd_retire),
        .we_i     (we),
        .wdata_i  (wdata),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    rs5_execute i_execute (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .stall_i            (stall_i),
        .op_i               (op_execute),
        .rd_i               (rd_execute),
        .operand1_i         (operand1),
        .operand2_i         (operand2),
        .store_data_i       (store_data),
        .pc_i               (pc_execute),
        .tag_i              (tag_execute),
        .mem_data_i         (mem_data_i),
        .jump_o             (jump),
        .jump_target_o      (jump_target),
        .fwd_rd_o           (fwd_rd),
        .fwd_data_o         (fwd_data),
        .fwd_is_load_o      (fwd_is_load),
        .killed_o           (killed),
        .mem_address_o      (mem_address_o),
        .mem_read_o         (mem_read),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_data_o),
        .we_o               (we),
        .rd_o               (rd_retire),
        .wdata_o            (wdata)
    );

    // No access from a wrong-path op or during a stall
    assign mem_operation_enable_o = !killed && !stall_i &&
                                    (mem_read || mem_write_enable_o != '0);

endmodule

/* verif/rs5_ref_model.svh */
/*
 * Instruction-set model and random program generator, included inside tb_rs5.
 * Loads and stores use x0 plus an immediate, so all data sits in the low 2 KB.
 * Branches and JAL only jump forward, which bounds the model run.
 */
`ifndef RS5_REF_MODEL_SVH
`define RS5_REF_MODEL_SVH

localparam int    PROG_LEN   = 120;
// Random part, 31 register dumps, one self-loop
localparam int    TOTAL_LEN  = PROG_LEN + 32;
localparam int    LOOP_IDX   = TOTAL_LEN - 1;
localparam int    IMEM_WORDS = 256;
localparam int    DMEM_WORDS = 512;
localparam word_t FINAL_BASE = 32'h0000_0400;

word_t     imem [IMEM_WORDS];
op_e       p_op [TOTAL_LEN];
reg_addr_t p_rd [TOTAL_LEN];
reg_addr_t p_rs1 [TOTAL_LEN];
reg_addr_t p_rs2 [TOTAL_LEN];
word_t     p_imm [TOTAL_LEN];
logic      p_useimm [TOTAL_LEN];
word_t     m_regs [32];
word_t     m_dmem [DMEM_WORDS];
// Expected accesses in program order, zero strobe for a read
word_t     exp_addr [$];
strb_t     exp_strb [$];
word_t     exp_data [$];

// Power-on data memory contents, distinct per word
function automatic word_t fill_word(int idx);
    word_t w;
    w = idx;
    return (w * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
endfunction

// Strobed lanes of data replace those of old
function automatic word_t merge_bytes(word_t old, word_t data, strb_t strb);
    word_t w;
    w = old;
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            w[b*8 +: 8] = data[b*8 +: 8];
        end
    end
    return w;
endfunction

// Mostly x0..x7 for dense dependencies
function automatic reg_addr_t pick_reg();
    word_t r;
    if ($urandom_range(0, 3) == 0) begin
        r = $urandom_range(0, 31);
    end
    else begin
        r = $urandom_range(0, 7);
    end
    return r[4:0];
endfunction

// RV32I funct3 of the register-register forms
function automatic logic [2:0] r_funct3(op_e op);
    case (op)
        OP_AND:  return 3'b111;
        OP_OR:   return 3'b110;
        OP_XOR:  return 3'b100;
        OP_SLT:  return 3'b010;
        default: return 3'b000;
    endcase
endfunction

////////////////////
// Program
////////////////////

task automatic gen_program();
    word_t     r;
    word_t     imm;
    int        tgt;
    op_e       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    for (int i = 0; i < IMEM_WORDS; i++) begin
        imem[i] = NOP_INSTR;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        r   = $urandom;
        imm = '0;
        p_useimm[i] = 1'b0;
        // Forward target 1..8 words ahead, never past the dumps
        tgt = i + 1 + r[15:13];
        if (tgt > PROG_LEN) begin
            tgt = PROG_LEN;
        end
        case ($urandom_range(0, 9))
            0, 1, 2, 3: begin
                case ($urandom_range(0, 5))
                    0:       op = OP_ADD;
                    1:       op = OP_SUB;
                    2:       op = OP_AND;
                    3:       op = OP_OR;
                    4:       op = OP_XOR;
                    default: op = OP_SLT;
                endcase
                imem[i] = {(op == OP_SUB) ? 7'h20 : 7'h00, rs2, rs1, r_funct3(op), rd, OPC_OP};
            end
            4: begin
                // ADDI, full signed 12-bit range
                op          = OP_ADD;
                imm         = {{20{r[11]}}, r[11:0]};
                p_useimm[i] = 1'b1;
                imem[i]     = {imm[11:0], rs1, 3'b000, rd, OPC_OPIMM};
            end
            5: begin
                op      = OP_LW;
                rs1     = '0;
                imm     = {22'b0, r[7:0], 2'b00};
                imem[i] = {imm[11:0], rs1, 3'b010, rd, OPC_LOAD};
            end
            6: begin
                op      = OP_SW;
                rs1     = '0;
                imm     = {22'b0, r[7:0], 2'b00};
                imem[i] = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
            end
            7: begin
                // Any byte lane
                op      = OP_SB;
                rs1     = '0;
                imm     = {22'b0, r[9:0]};
                imem[i] = {imm[11:5], rs2, rs1, 3'b000, imm[4:0], OPC_STORE};
            end
            8: begin
                op      = r[12] ? OP_BNE : OP_BEQ;
                imm     = (tgt - i) * 4;
                imem[i] = {imm[12], imm[10:5], rs2, rs1, {2'b00, r[12]}, imm[4:1], imm[11],
                           OPC_BRANCH};
            end
            default: begin
                op      = OP_JAL;
                imm     = (tgt - i) * 4;
                imem[i] = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
            end
        endcase
        p_op[i]  = op;
        p_rd[i]  = rd;
        p_rs1[i] = rs1;
        p_rs2[i] = rs2;
        p_imm[i] = imm;
    end
    // SW xk to FINAL_BASE + 4*(k-1)
    for (int k = 1; k < 32; k++) begin
        imm                    = FINAL_BASE + 4 * (k - 1);
        rs2                    = k[4:0];
        p_op[PROG_LEN+k-1]     = OP_SW;
        p_rd[PROG_LEN+k-1]     = '0;
        p_rs1[PROG_LEN+k-1]    = '0;
        p_rs2[PROG_LEN+k-1]    = rs2;
        p_imm[PROG_LEN+k-1]    = imm;
        p_useimm[PROG_LEN+k-1] = 1'b0;
        imem[PROG_LEN+k-1]     = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};
    end
    // BEQ x0,x0,0
    p_op[LOOP_IDX]  = OP_BEQ;
    p_imm[LOOP_IDX] = '0;
    imem[LOOP_IDX]  = {7'd0, 5'd0, 5'd0, 3'b000, 5'd0, OPC_BRANCH};
endtask

////////////////////
// Model run
////////////////////

task automatic run_model();
    int    pc;
    int    nxt;
    word_t a;
    word_t b;
    word_t res;
    word_t addr;
    word_t data;
    strb_t strb;
    logic  wr;
    for (int r = 0; r < 32; r++) begin
        m_regs[r] = '0;
    end
    for (int w = 0; w < DMEM_WORDS; w++) begin
        m_dmem[w] = fill_word(w);
    end
    pc = 0;
    while (pc != LOOP_IDX) begin
        a    = m_regs[p_rs1[pc]];
        b    = p_useimm[pc] ? p_imm[pc] : m_regs[p_rs2[pc]];
        addr = a + p_imm[pc];
        nxt  = pc + 1;
        wr   = 1'b1;
        res  = '0;
        case (p_op[pc])
            OP_ADD: res = a + b;
            OP_SUB: res = a - b;
            OP_AND: res = a & b;
            OP_OR:  res = a | b;
            OP_XOR: res = a ^ b;
            OP_SLT: res = {31'b0, $signed(a) < $signed(b)};
            OP_LW: begin
                res = m_dmem[addr[10:2]];
                exp_addr.push_back(addr);
                exp_strb.push_back(4'b0000);
                exp_data.push_back('0);
            end
            OP_SW, OP_SB: begin
                wr = 1'b0;
                if (p_op[pc] == OP_SW) begin
                    strb = 4'b1111;
                    data = b;
                end
                else begin
                    // Byte on every lane, strobe from the low address bits
                    strb = 4'b0001 << addr[1:0];
                    data = {4{b[7:0]}};
                end
                m_dmem[addr[10:2]] = merge_bytes(m_dmem[addr[10:2]], data, strb);
                exp_addr.push_back(addr);
                exp_strb.push_back(strb);
                exp_data.push_back(data);
            end
            OP_BEQ, OP_BNE: begin
                wr = 1'b0;
                if ((a == b) == (p_op[pc] == OP_BEQ)) begin
                    nxt = pc + p_imm[pc][31:2];
                end
            end
            OP_JAL: begin
                res = (pc + 1) * 4;
                nxt = pc + p_imm[pc][31:2];
            end
            default: wr = 1'b0;
        endcase
        if (wr && p_rd[pc] != '0) begin
            m_regs[p_rd[pc]] = res;
        end
        pc = nxt;
    end
endtask

`endif

/* verif/tb_rs5.sv */
/*
 * Testbench for the RS5 core. A random program from a fixed seed is checked
 * against the instruction-set model, memory access by access. Both memories
 * answer one cycle after the request; only memory traffic is observed.
 */
`timescale 1ns/100ps

module tb_rs5
    import rs5_pkg::*;
();

    `include "rs5_ref_model.svh"

    localparam word_t RESET_PC = '0;
    localparam word_t LOOP_PC  = LOOP_IDX * 4;
    localparam int    TIMEOUT  = (PROG_LEN + 31) * 6 + 100;

    logic  clk;
    logic  rst_n_i;
    logic  stall_i;
    word_t instruction_i;
    word_t mem_data_i;
    word_t instruction_address_o;
    word_t mem_address_o;
    word_t mem_data_o;
    logic  mem_operation_enable_o;
    strb_t mem_write_enable_o;

    word_t dmem [DMEM_WORDS];
    word_t iaddr_q;
    logic  read_q;
    word_t rdata_q;
    int    loop_hits;
    int    cycles;
    int    value_errors;
    int    access_errors;
    int    other_errors;
    int    checked;
    int    seed;

    rs5 #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .stall_i                (stall_i),
        .instruction_i          (instruction_i),
        .mem_data_i             (mem_data_i),
        .instruction_address_o  (instruction_address_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_strobe(input string name, input strb_t got, input strb_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Enabled access against the oldest model access
    task automatic check_access();
        word_t e_addr;
        strb_t e_strb;
        word_t e_data;
        if (exp_addr.size() == 0) begin
            access_errors++;
            $display("%0t: unexpected memory access to %h after the model ran out of accesses",
                     $time, mem_address_o);
        end
        else begin
            e_addr = exp_addr.pop_front();
            e_strb = exp_strb.pop_front();
            e_data = exp_data.pop_front();
            check_word("mem_address_o", mem_address_o, e_addr);
            // Zero strobe marks a read
            check_strobe("mem_write_enable_o", mem_write_enable_o, e_strb);
            if (e_strb != '0) begin
                check_word("mem_data_o", mem_data_o, e_data);
            end
            checked++;
        end
    endtask

    ////////////////////
    // Memories
    ////////////////////

    // Requests taken on the rising edge
    always @(posedge clk) begin
        iaddr_q <= instruction_address_o;
        read_q  <= 1'b0;
        if (!rst_n_i) begin
            for (int w = 0; w < DMEM_WORDS; w++) begin
                dmem[w] <= fill_word(w);
            end
        end
        else if (mem_operation_enable_o) begin
            if (stall_i) begin
                access_errors++;
                $display("%0t: memory access enabled while stall_i is high", $time);
            end
            check_access();
            if (mem_write_enable_o == '0) begin
                read_q  <= 1'b1;
                rdata_q <= dmem[mem_address_o[10:2]];
            end
            else begin
                dmem[mem_address_o[10:2]] <= merge_bytes(dmem[mem_address_o[10:2]],
                                                         mem_data_o, mem_write_enable_o);
            end
        end
        // Self-loop seen with nothing left to do
        if (rst_n_i && exp_addr.size() == 0 && instruction_address_o == LOOP_PC) begin
            loop_hits++;
        end
    end

    // Responses on the falling edge
    always @(negedge clk) begin
        instruction_i <= imem[iaddr_q[9:2]];
        // Read data held between reads
        if (read_q) begin
            mem_data_i <= rdata_q;
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        seed = 81879;
        void'($urandom(seed));
        rst_n_i       = 1'b0;
        stall_i       = 1'b0;
        instruction_i = NOP_INSTR;
        mem_data_i    = '0;
        loop_hits     = 0;
        value_errors  = 0;
        access_errors = 0;
        other_errors  = 0;
        checked       = 0;
        gen_program();
        run_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_word("instruction_address_o", instruction_address_o, RESET_PC);
        check_bit("mem_operation_enable_o", mem_operation_enable_o, 1'b0);
        rst_n_i <= 1'b1;
        cycles = 0;
        // A few turns of the self-loop catch stray wrong-path accesses
        while (loop_hits < 3 && cycles < TIMEOUT) begin
            @(negedge clk);
            // Single-cycle stall pulses
            stall_i <= !stall_i && ($urandom_range(0, 7) == 0);
            cycles++;
        end
        if (loop_hits < 3) begin
            other_errors++;
            $display("timeout after %0d cycles with %0d expected accesses never seen",
                     cycles, exp_addr.size());
        end
        $display("value errors %0d, access errors %0d, other errors %0d, accesses checked %0d",
                 value_errors, access_errors, other_errors, checked);
        if (value_errors == 0 && access_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end
        else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+verif
verilog/rs5_pkg.sv
verilog/rs5_fetch.sv
verilog/rs5_regbank.sv
verilog/rs5_decode.sv
verilog/rs5_execute.sv
verilog/rs5.sv
verif/tb_rs5.sv
